// ==== filelist.f ====
verilog/video_pkg.sv
verilog/raster_counter.sv
verilog/sync_decoder.sv
verilog/picture_generator.sv
verilog/video_output_stage.sv
verilog/video_timing_top.sv
sim/tb_video_timing_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module tb_video_timing_top \
    -o tb_video_timing_top > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_video_timing_top > sim.log 2>&1
cat sim.log

! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_video_timing_top.sv ====
`default_nettype none

module tb_video_timing_top
    import video_pkg::*;
();

    localparam int HALF_PERIOD    = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_MARGIN = 1000;
    localparam int PAL_FRAME      = (int'(PAL_H_LAST) + 1) * (int'(PAL_V_LAST) + 1);
    localparam int NTSC_FRAME     = (int'(NTSC_H_LAST) + 1) * (int'(NTSC_V_LAST) + 1);

    logic                clk;
    logic                rst_n;
    video_mode_e         mode_request;
    logic [COLOUR_W-1:0] border_colour;
    logic                csync_n;
    logic                hsync_n;
    logic                vsync_n;
    logic                blank;
    logic [COLOUR_W-1:0] colour;
    logic [POS_W-1:0]    h_pos;
    logic [POS_W-1:0]    v_pos;

    // Tests from the data file
    int test_ids[$];
    int test_modes[$];
    int test_borders[$];
    int test_frames[$];
    int test_num;
    int cycle_count = 0;
    int cycle_limit;

    // Reference raster, the position the counter holds now
    logic [POS_W-1:0]    model_h;
    logic [POS_W-1:0]    model_v;
    video_mode_e         model_mode;

    // Expected output register contents
    logic [POS_W-1:0]    exp_h;
    logic [POS_W-1:0]    exp_v;
    logic                exp_hsync_n;
    logic                exp_vsync_n;
    logic                exp_csync_n;
    logic                exp_blank;
    logic [COLOUR_W-1:0] exp_colour;

    video_timing_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode_request  (mode_request),
        .border_colour (border_colour),
        .csync_n       (csync_n),
        .hsync_n       (hsync_n),
        .vsync_n       (vsync_n),
        .blank         (blank),
        .colour        (colour),
        .h_pos         (h_pos),
        .v_pos         (v_pos)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic in_window(input logic [POS_W-1:0] pos,
                                       input logic [POS_W-1:0] first,
                                       input logic [POS_W-1:0] last);
        return (pos >= first) && (pos <= last);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // What the output stage captures from the current position
    task automatic predict_outputs();
        logic hblank;
        logic vblank;
        logic hsync;
        logic vsync;
        int   offset;
        if (model_mode == MODE_NTSC) begin
            hblank = model_h >= NTSC_HBLANK_FIRST;
            vblank = in_window(model_v, NTSC_VBLANK_FIRST, NTSC_VBLANK_LAST);
            hsync  = in_window(model_h, NTSC_HSYNC_FIRST, NTSC_HSYNC_LAST);
            vsync  = in_window(model_v, NTSC_VSYNC_FIRST, NTSC_VSYNC_LAST);
        end else begin
            hblank = model_h >= PAL_HBLANK_FIRST;
            vblank = model_v >= PAL_VBLANK_FIRST;
            hsync  = in_window(model_h, PAL_HSYNC_FIRST, PAL_HSYNC_LAST);
            vsync  = in_window(model_v, PAL_VSYNC_FIRST, PAL_VSYNC_LAST);
        end
        offset      = int'(model_h) - int'(PAPER_H_FIRST);
        exp_h       = model_h;
        exp_v       = model_v;
        exp_hsync_n = !hsync;
        exp_vsync_n = !vsync;
        exp_csync_n = !(hsync || vsync);
        exp_blank   = hblank || vblank;
        if (exp_blank) begin
            exp_colour = '0;
        end else if (in_window(model_h, PAPER_H_FIRST, PAPER_H_LAST)
                     && in_window(model_v, PAPER_V_FIRST, PAPER_V_LAST)) begin
            exp_colour = COLOUR_W'(offset / 32);
        end else begin
            exp_colour = border_colour;
        end
    endtask

    task automatic step_model();
        logic [POS_W-1:0] h_last;
        logic [POS_W-1:0] v_last;
        h_last = (model_mode == MODE_NTSC) ? NTSC_H_LAST : PAL_H_LAST;
        v_last = (model_mode == MODE_NTSC) ? NTSC_V_LAST : PAL_V_LAST;
        if (model_h != h_last) begin
            model_h = model_h + 1'b1;
        end else begin
            model_h = '0;
            if (model_v != v_last) begin
                model_v = model_v + 1'b1;
            end else begin
                // Requested standard only from the next frame on
                model_v    = '0;
                model_mode = mode_request;
            end
        end
    endtask

    task automatic check_value(input string signal_name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Error test %0d %s: expected %0d, actual %0d",
                     test_num, signal_name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_outputs();
        check_value("h_pos", int'(exp_h), int'(h_pos));
        check_value("v_pos", int'(exp_v), int'(v_pos));
        check_value("hsync_n", int'(exp_hsync_n), int'(hsync_n));
        check_value("vsync_n", int'(exp_vsync_n), int'(vsync_n));
        check_value("csync_n", int'(exp_csync_n), int'(csync_n));
        check_value("blank", int'(exp_blank), int'(blank));
        check_value("colour", int'(exp_colour), int'(colour));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        string line;
        int    t;
        int    m;
        int    b;
        int    f;
        int    total_frames;
        int    cycles;
        clk           = 1'b0;
        rst_n         = 1'b0;
        mode_request  = MODE_PAL;
        border_colour = '0;
        test_num      = 0;
        total_frames  = 0;
        fd = $fopen("sim/video_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/video_input.txt");
            $display("ERRORS FOUND");
            $fatal(1, "Missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %d %d %d", t, m, b, f) == 4) begin
                    test_ids.push_back(t);
                    test_modes.push_back(m);
                    test_borders.push_back(b);
                    test_frames.push_back(f);
                    total_frames += f;
                end
            end
        end
        $fclose(fd);
        // No frame is longer than a PAL frame
        cycle_limit = total_frames * PAL_FRAME + TIMEOUT_MARGIN;

        model_h     = '0;
        model_v     = '0;
        model_mode  = MODE_PAL;
        exp_h       = '0;
        exp_v       = '0;
        exp_hsync_n = 1'b1;
        exp_vsync_n = 1'b1;
        exp_csync_n = 1'b1;
        exp_blank   = 1'b1;
        exp_colour  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_outputs();
        rst_n = 1'b1;

        foreach (test_ids[i]) begin
            test_num      = test_ids[i];
            mode_request  = (test_modes[i] != 0) ? MODE_NTSC : MODE_PAL;
            border_colour = COLOUR_W'(test_borders[i]);
            cycles = test_frames[i] * ((test_modes[i] != 0) ? NTSC_FRAME : PAL_FRAME);
            repeat (cycles) begin
                predict_outputs();
                step_model();
                @(negedge clk);
                check_outputs();
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/video_input.txt ====
# test mode border frames
# mode 0 is PAL, 1 is NTSC; border is a colour index 0 to 7
1 0 7 1
2 0 2 1
3 1 5 1
4 1 3 1
5 1 6 1
6 0 1 1
7 0 4 1
8 1 0 1
9 1 7 1
10 0 5 1
11 1 2 1
12 0 6 1
13 0 3 1
14 1 4 1
15 1 1 1
16 0 7 1

// ==== verilog/picture_generator.sv ====
`default_nettype none

module picture_generator
    import video_pkg::*;
(
    input  wire logic [POS_W-1:0]    h_pos,
    input  wire logic [POS_W-1:0]    v_pos,
    input  wire logic [COLOUR_W-1:0] border_colour,
    output logic [COLOUR_W-1:0]      colour
);

    region_e          region;
    logic             in_h_paper;
    logic             in_v_paper;
    logic [POS_W-1:0] h_offset;

    ////////////////////////////////////////////////////////////////////////////
    // Region classification
    ////////////////////////////////////////////////////////////////////////////

    assign in_h_paper = (h_pos >= PAPER_H_FIRST) && (h_pos <= PAPER_H_LAST);
    assign in_v_paper = (v_pos >= PAPER_V_FIRST) && (v_pos <= PAPER_V_LAST);

    always_comb begin
        if (in_h_paper && in_v_paper) begin
            region = REGION_PAPER;
        end else begin
            region = REGION_BORDER;
        end
    end

    // Offset into the paper, 0 to 255 across the window
    assign h_offset = h_pos - PAPER_H_FIRST;

    ////////////////////////////////////////////////////////////////////////////
    // Colour select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (region)
            REGION_PAPER: begin
                // Eight bars, 32 pixels each
                colour = h_offset[7:5];
            end
            default: begin
                colour = border_colour;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/raster_counter.sv ====
`default_nettype none

module raster_counter
    import video_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire video_mode_e mode_request,
    output logic [POS_W-1:0] h_pos,
    output logic [POS_W-1:0] v_pos,
    output video_mode_e      mode
);

    logic [POS_W-1:0] h_last;
    logic [POS_W-1:0] v_last;
    logic             line_end;
    logic             frame_end;

    // Wrap limits follow the standard of the frame in progress
    always_comb begin
        if (mode == MODE_NTSC) begin
            h_last = NTSC_H_LAST;
            v_last = NTSC_V_LAST;
        end else begin
            h_last = PAL_H_LAST;
            v_last = PAL_V_LAST;
        end
    end

    assign line_end  = (h_pos == h_last);
    assign frame_end = line_end && (v_pos == v_last);

    ////////////////////////////////////////////////////////////////////////////
    // Position counters and mode register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_pos <= '0;
            v_pos <= '0;
            mode  <= MODE_PAL;
        end else begin
            if (line_end) begin
                h_pos <= '0;
                if (frame_end) begin
                    v_pos <= '0;
                    // New standard starts with the first pixel of the next frame
                    mode  <= mode_request;
                end else begin
                    v_pos <= v_pos + 1'b1;
                end
            end else begin
                h_pos <= h_pos + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sync_decoder.sv ====
`default_nettype none

module sync_decoder
    import video_pkg::*;
(
    input  wire logic [POS_W-1:0] h_pos,
    input  wire logic [POS_W-1:0] v_pos,
    input  wire video_mode_e      mode,
    output logic                  hsync_n,
    output logic                  vsync_n,
    output logic                  blank
);

    logic [POS_W-1:0] hblank_first;
    logic [POS_W-1:0] vblank_first;
    logic [POS_W-1:0] vblank_last;
    logic [POS_W-1:0] hsync_first;
    logic [POS_W-1:0] hsync_last;
    logic [POS_W-1:0] vsync_first;
    logic [POS_W-1:0] vsync_last;
    logic             hblank;
    logic             vblank;

    ////////////////////////////////////////////////////////////////////////////
    // Window limits per standard
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (mode == MODE_NTSC) begin
            hblank_first = NTSC_HBLANK_FIRST;
            vblank_first = NTSC_VBLANK_FIRST;
            vblank_last  = NTSC_VBLANK_LAST;
            hsync_first  = NTSC_HSYNC_FIRST;
            hsync_last   = NTSC_HSYNC_LAST;
            vsync_first  = NTSC_VSYNC_FIRST;
            vsync_last   = NTSC_VSYNC_LAST;
        end else begin
            // PAL blanking runs to the end of line and frame
            hblank_first = PAL_HBLANK_FIRST;
            vblank_first = PAL_VBLANK_FIRST;
            vblank_last  = PAL_V_LAST;
            hsync_first  = PAL_HSYNC_FIRST;
            hsync_last   = PAL_HSYNC_LAST;
            vsync_first  = PAL_VSYNC_FIRST;
            vsync_last   = PAL_VSYNC_LAST;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window compares
    ////////////////////////////////////////////////////////////////////////////

    // Horizontal blanking always runs to the line end
    assign hblank = (h_pos >= hblank_first);
    assign vblank = (v_pos >= vblank_first) && (v_pos <= vblank_last);

    // Active low inside the sync windows
    assign hsync_n = !((h_pos >= hsync_first) && (h_pos <= hsync_last));
    assign vsync_n = !((v_pos >= vsync_first) && (v_pos <= vsync_last));

    assign blank = hblank | vblank;

endmodule

`default_nettype wire

// ==== verilog/video_output_stage.sv ====
`default_nettype none

module video_output_stage
    import video_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [POS_W-1:0]    h_pos,
    input  wire logic [POS_W-1:0]    v_pos,
    input  wire logic                hsync_n,
    input  wire logic                vsync_n,
    input  wire logic                blank,
    input  wire logic [COLOUR_W-1:0] colour,
    output logic                     csync_n,
    output logic                     out_hsync_n,
    output logic                     out_vsync_n,
    output logic                     out_blank,
    output logic [COLOUR_W-1:0]      out_colour,
    output logic [POS_W-1:0]         out_h_pos,
    output logic [POS_W-1:0]         out_v_pos
);

    logic                csync_n_next;
    logic [COLOUR_W-1:0] colour_next;

    // Composite sync is low while either sync is low
    assign csync_n_next = hsync_n & vsync_n;

    // Black during blanking
    assign colour_next = blank ? '0 : colour;

    ////////////////////////////////////////////////////////////////////////////
    // Output registers, aligned with the position they describe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csync_n     <= 1'b1;
            out_hsync_n <= 1'b1;
            out_vsync_n <= 1'b1;
            out_blank   <= 1'b1;
            out_colour  <= '0;
            out_h_pos   <= '0;
            out_v_pos   <= '0;
        end else begin
            csync_n     <= csync_n_next;
            out_hsync_n <= hsync_n;
            out_vsync_n <= vsync_n;
            out_blank   <= blank;
            out_colour  <= colour_next;
            out_h_pos   <= h_pos;
            out_v_pos   <= v_pos;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/video_pkg.sv ====
`default_nettype none

package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        MODE_PAL  = 1'b0,
        MODE_NTSC = 1'b1
    } video_mode_e;

    typedef enum logic {
        REGION_BORDER = 1'b0,
        REGION_PAPER  = 1'b1
    } region_e;

    localparam int POS_W    = 9;
    localparam int COLOUR_W = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Raster limits, last count of each counter
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [POS_W-1:0] PAL_H_LAST  = 9'd447;
    localparam logic [POS_W-1:0] PAL_V_LAST  = 9'd311;
    localparam logic [POS_W-1:0] NTSC_H_LAST = 9'd444;
    localparam logic [POS_W-1:0] NTSC_V_LAST = 9'd261;

    // Blanking windows, inclusive
    localparam logic [POS_W-1:0] PAL_HBLANK_FIRST  = 9'd352;
    localparam logic [POS_W-1:0] PAL_VBLANK_FIRST  = 9'd304;
    localparam logic [POS_W-1:0] NTSC_HBLANK_FIRST = 9'd320;
    localparam logic [POS_W-1:0] NTSC_VBLANK_FIRST = 9'd240;
    // NTSC vertical blank stops two lines short of the frame end
    localparam logic [POS_W-1:0] NTSC_VBLANK_LAST  = 9'd259;

    // Sync windows, inclusive
    localparam logic [POS_W-1:0] PAL_HSYNC_FIRST  = 9'd376;
    localparam logic [POS_W-1:0] PAL_HSYNC_LAST   = 9'd407;
    localparam logic [POS_W-1:0] PAL_VSYNC_FIRST  = 9'd304;
    localparam logic [POS_W-1:0] PAL_VSYNC_LAST   = 9'd307;
    localparam logic [POS_W-1:0] NTSC_HSYNC_FIRST = 9'd360;
    localparam logic [POS_W-1:0] NTSC_HSYNC_LAST  = 9'd390;
    localparam logic [POS_W-1:0] NTSC_VSYNC_FIRST = 9'd243;
    localparam logic [POS_W-1:0] NTSC_VSYNC_LAST  = 9'd245;

    // Paper window, shared by both standards
    localparam logic [POS_W-1:0] PAPER_H_FIRST = 9'd32;
    localparam logic [POS_W-1:0] PAPER_H_LAST  = 9'd287;
    localparam logic [POS_W-1:0] PAPER_V_FIRST = 9'd48;
    localparam logic [POS_W-1:0] PAPER_V_LAST  = 9'd239;

endpackage

`default_nettype wire

// ==== verilog/video_timing_top.sv ====
`default_nettype none

module video_timing_top
    import video_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire video_mode_e         mode_request,
    input  wire logic [COLOUR_W-1:0] border_colour,
    output logic                     csync_n,
    output logic                     hsync_n,
    output logic                     vsync_n,
    output logic                     blank,
    output logic [COLOUR_W-1:0]      colour,
    output logic [POS_W-1:0]         h_pos,
    output logic [POS_W-1:0]         v_pos
);

    // Raster position and mode, before the output register
    logic [POS_W-1:0]    raw_h_pos;
    logic [POS_W-1:0]    raw_v_pos;
    video_mode_e         mode;
    logic                raw_hsync_n;
    logic                raw_vsync_n;
    logic                raw_blank;
    logic [COLOUR_W-1:0] raw_colour;

    raster_counter u_raster_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode_request (mode_request),
        .h_pos        (raw_h_pos),
        .v_pos        (raw_v_pos),
        .mode         (mode)
    );

    sync_decoder u_sync_decoder (
        .h_pos   (raw_h_pos),
        .v_pos   (raw_v_pos),
        .mode    (mode),
        .hsync_n (raw_hsync_n),
        .vsync_n (raw_vsync_n),
        .blank   (raw_blank)
    );

    picture_generator u_picture_generator (
        .h_pos         (raw_h_pos),
        .v_pos         (raw_v_pos),
        .border_colour (border_colour),
        .colour        (raw_colour)
    );

    video_output_stage u_video_output_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .h_pos       (raw_h_pos),
        .v_pos       (raw_v_pos),
        .hsync_n     (raw_hsync_n),
        .vsync_n     (raw_vsync_n),
        .blank       (raw_blank),
        .colour      (raw_colour),
        .csync_n     (csync_n),
        .out_hsync_n (hsync_n),
        .out_vsync_n (vsync_n),
        .out_blank   (blank),
        .out_colour  (colour),
        .out_h_pos   (h_pos),
        .out_v_pos   (v_pos)
    );

endmodule

`default_nettype wire
